// ==== tinyCore.f ====
common/corePkg.sv
common/memReqIf.sv
source/hazardCtrl.sv
source/fetchUnit.sv
execute/intExec.sv
execute/iterDivider.sv
source/apbMaster.sv
source/coreTop.sv
testbench/coreTb_sva.sv
testbench/coreTb.sv

// ==== build.sh ====
#!/bin/sh
# build and run the tinyCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module coreTb -f tinyCore.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/VcoreTb)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

// ==== testbench/coreTb.sv ====
////////////////////
// directed tests, apb slave decodes reads on paddr[3:0] only
////////////////////
`timescale 1ns/1ps
`default_nettype none

module coreTb;

  localparam int clkPeriod  = 8;
  localparam int numTests   = 5;
  localparam int haltLimit  = 400;   // cycles allowed per run
  localparam int watchdogNs = numTests * 200 * clkPeriod + 2000;

  logic           clk = 1'b0;
  logic           rstN;
  logic           imemWe;
  corePkg::word_t imemAddr;
  corePkg::word_t imemWdata;
  logic           run;
  logic           halted, busFault;
  corePkg::word_t paddr, pwdata;
  logic           psel, penable, pwrite;
  corePkg::word_t prdata  = '0;
  logic           pready  = 1'b0;
  logic           pslverr = 1'b0;

  ////////////////////
  // slave model and scoreboard
  corePkg::word_t readMem [16];
  corePkg::word_t wrAddrQ[$];
  corePkg::word_t wrDataQ[$];
  corePkg::word_t expAddrQ[$];
  corePkg::word_t expDataQ[$];
  logic           errArm  = 1'b0;   // answer a store to errAddr with pslverr
  corePkg::word_t errAddr = '0;
  int             waitLeft;
  corePkg::word_t prog[$];
  int             errors = 0;

  coreTop #(.imemDepth(64)) dut_i (
    .clk, .rstN, .imemWe, .imemAddr, .imemWdata, .run,
    .halted, .busFault,
    .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
  );

  always #(clkPeriod / 2) clk = ~clk;

  // apb slave, 0..3 random wait states per transfer
  always @(posedge clk) begin
    if (!rstN) begin
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end else if (psel && !penable) begin
      waitLeft = int'($urandom_range(3, 0));
      pready  <= (waitLeft == 0);
      pslverr <= errArm && pwrite && (paddr == errAddr);
      prdata  <= readMem[paddr[3:0]];
    end else if (psel && penable && !pready) begin
      waitLeft = waitLeft - 1;
      if (waitLeft == 0) begin
        pready <= 1'b1;
      end
    end else if (psel && penable && pready) begin
      if (pwrite) begin
        wrAddrQ.push_back(paddr);   // log every completed write
        wrDataQ.push_back(pwdata);
      end
      pready  <= 1'b0;
      pslverr <= 1'b0;
    end
  end

  ////////////////////
  // helpers
  function automatic corePkg::word_t encode(corePkg::opcode_t op, int rd, int rs1, int rs2,
                                            int imm);
    corePkg::instr_t ins;
    ins.op  = op;
    ins.rd  = corePkg::regIdx_t'(rd);
    ins.rs1 = corePkg::regIdx_t'(rs1);
    ins.rs2 = corePkg::regIdx_t'(rs2);
    ins.imm = 16'(imm);   // low 16 bits, signed
    return corePkg::word_t'(ins);
  endfunction

  task automatic checkWord(input string what, input corePkg::word_t got,
                           input corePkg::word_t exp);
    if (got !== exp) begin
      $display("ERROR @%0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic checkFlag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR @%0t ns: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic clearLogs();
    wrAddrQ.delete();
    wrDataQ.delete();
    expAddrQ.delete();
    expDataQ.delete();
  endtask

  task automatic expectWrite(input corePkg::word_t addr, input corePkg::word_t data);
    expAddrQ.push_back(addr);
    expDataQ.push_back(data);
  endtask

  task automatic loadProgram();
    int i;
    for (i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      imemWe    <= 1'b1;
      imemAddr  <= corePkg::word_t'(i);
      imemWdata <= prog[i];
    end
    @(posedge clk);
    imemWe <= 1'b0;
  endtask

  // pulse run, then wait for halted
  task automatic runUntilHalt(input string name);
    int cycles;
    @(posedge clk);
    run <= 1'b1;
    @(posedge clk);
    run <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!halted && cycles < haltLimit);
    if (!halted) begin
      $display("%s: core did not halt within %0d cycles", name, haltLimit);
      errors++;
    end
  endtask

  task automatic compareWrites(input string name);
    int i;
    checkWord({name, " write count"}, corePkg::word_t'(wrAddrQ.size()),
              corePkg::word_t'(expAddrQ.size()));
    for (i = 0; i < expAddrQ.size() && i < wrAddrQ.size(); i++) begin
      checkWord($sformatf("%s write %0d addr", name, i), wrAddrQ[i], expAddrQ[i]);
      checkWord($sformatf("%s write %0d data", name, i), wrDataQ[i], expDataQ[i]);
    end
  endtask

  ////////////////////
  // tests
  task automatic aluTest();
    corePkg::word_t a, b;
    int r;
    a = 32'd100;
    b = 32'hFFFF_FFF9;   // -7
    prog.delete();
    clearLogs();
    prog.push_back(encode(corePkg::OP_ADDI, 1, 0, 0, 100));
    prog.push_back(encode(corePkg::OP_ADDI, 2, 0, 0, -7));
    prog.push_back(encode(corePkg::OP_ADD, 3, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_SUB, 4, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_AND, 5, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_XOR, 6, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_ADDI, 0, 0, 0, 55));   // r0 must stay zero
    for (r = 0; r <= 6; r++) begin
      prog.push_back(encode(corePkg::OP_STORE, 0, 0, r, 16 + r));
    end
    prog.push_back(encode(corePkg::OP_HALT, 0, 0, 0, 0));
    expectWrite(32'h10, 32'h0);
    expectWrite(32'h11, a);
    expectWrite(32'h12, b);
    expectWrite(32'h13, a + b);
    expectWrite(32'h14, a - b);
    expectWrite(32'h15, a & b);
    expectWrite(32'h16, a ^ b);
    loadProgram();
    runUntilHalt("alu");
    compareWrites("alu");
  endtask

  task automatic loadTest();
    corePkg::word_t sum;
    int i;
    prog.delete();
    clearLogs();
    for (i = 0; i < 16; i++) begin
      readMem[i] = $urandom;
    end
    for (i = 1; i <= 4; i++) begin
      prog.push_back(encode(corePkg::OP_LOAD, i, 0, 0, i - 1));
    end
    prog.push_back(encode(corePkg::OP_ADD, 5, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_ADD, 5, 5, 3, 0));
    prog.push_back(encode(corePkg::OP_ADD, 5, 5, 4, 0));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 5, 32'h20));
    prog.push_back(encode(corePkg::OP_HALT, 0, 0, 0, 0));
    sum = readMem[0] + readMem[1] + readMem[2] + readMem[3];
    expectWrite(32'h20, sum);
    loadProgram();
    runUntilHalt("loads");
    compareWrites("loads");
  endtask

  task automatic branchTest();
    prog.delete();
    clearLogs();
    prog.push_back(encode(corePkg::OP_ADDI, 1, 0, 0, 5));
    prog.push_back(encode(corePkg::OP_ADDI, 2, 0, 0, 5));
    prog.push_back(encode(corePkg::OP_ADDI, 3, 0, 0, 6));
    prog.push_back(encode(corePkg::OP_BEQ, 0, 1, 3, 2));        // 5 != 6, falls through
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h30));
    prog.push_back(encode(corePkg::OP_BEQ, 0, 1, 2, 3));        // taken, to word 8
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h31)); // flushed
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h32)); // skipped
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 2, 32'h33)); // target
    prog.push_back(encode(corePkg::OP_HALT, 0, 0, 0, 0));
    expectWrite(32'h30, 32'd5);
    expectWrite(32'h33, 32'd5);
    loadProgram();
    runUntilHalt("branch");
    compareWrites("branch");
  endtask

  task automatic divideTest();
    corePkg::word_t a, b;
    a = $urandom;
    b = ($urandom >> 12) + 1;   // nonzero, gives a wide quotient
    readMem[4] = a;
    readMem[5] = b;
    prog.delete();
    clearLogs();
    prog.push_back(encode(corePkg::OP_LOAD, 1, 0, 0, 4));
    prog.push_back(encode(corePkg::OP_LOAD, 2, 0, 0, 5));
    prog.push_back(encode(corePkg::OP_DIVU, 3, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_REMU, 4, 1, 2, 0));
    prog.push_back(encode(corePkg::OP_DIVU, 5, 1, 0, 0));   // divide by r0
    prog.push_back(encode(corePkg::OP_REMU, 6, 1, 0, 0));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 3, 32'h40));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 4, 32'h41));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 5, 32'h42));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 6, 32'h43));
    prog.push_back(encode(corePkg::OP_HALT, 0, 0, 0, 0));
    expectWrite(32'h40, a / b);
    expectWrite(32'h41, a % b);
    expectWrite(32'h42, 32'hFFFF_FFFF);   // zero divisor, all ones
    expectWrite(32'h43, a);               // zero divisor, dividend back
    loadProgram();
    runUntilHalt("divide");
    compareWrites("divide");
  endtask

  task automatic busErrorTest();
    prog.delete();
    clearLogs();
    prog.push_back(encode(corePkg::OP_ADDI, 1, 0, 0, 32'h11));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h50));
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h51));   // faults
    prog.push_back(encode(corePkg::OP_STORE, 0, 0, 1, 32'h52));   // never issued
    prog.push_back(encode(corePkg::OP_HALT, 0, 0, 0, 0));
    errAddr <= 32'h51;
    errArm  <= 1'b1;
    expectWrite(32'h50, 32'h11);
    expectWrite(32'h51, 32'h11);
    loadProgram();
    runUntilHalt("bus error");
    repeat (10) @(posedge clk);   // bus must stay quiet
    compareWrites("bus error");
    checkFlag("busFault after error", busFault, 1'b1);
    checkFlag("halted after error", halted, 1'b1);

    // healthy slave, same program again from word 0
    errArm <= 1'b0;
    clearLogs();
    expectWrite(32'h50, 32'h11);
    expectWrite(32'h51, 32'h11);
    expectWrite(32'h52, 32'h11);
    runUntilHalt("restart");
    compareWrites("restart");
    checkFlag("busFault after restart", busFault, 1'b0);
  endtask

  ////////////////////
  // main sequence
  initial begin
    void'($urandom(75));
    rstN      = 1'b0;
    imemWe    = 1'b0;
    imemAddr  = '0;
    imemWdata = '0;
    run       = 1'b0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
    aluTest();
    loadTest();
    branchTest();
    divideTest();
    busErrorTest();
    errors += dut_i.sva_i.assertFails;
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // hard stop in case the core locks up
  initial begin
    #(watchdogNs);
    $display("watchdog expired after %0d ns, tests did not finish", watchdogNs);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/coreTb_sva.sv ====
////////////////////
// bound into coreTop, sees only its ports
////////////////////
`timescale 1ns/1ps
`default_nettype none

module coreTb_sva (
  input logic           clk,
  input logic           rstN,
  input logic           run,
  input logic           halted,
  input logic           psel,
  input logic           penable,
  input logic           pready,
  input logic           pwrite,
  input corePkg::word_t paddr
);

  int assertFails = 0;   // summed into the testbench error count

  ////////////////////
  // apb protocol
  // access held with psel through wait states
  accessHeld: assert property (@(posedge clk) disable iff (!rstN)
    penable && !pready |=> psel && penable)
    else begin
      assertFails++;
      $error("access phase dropped before pready");
    end

  // wait states must not disturb the request
  accessStable: assert property (@(posedge clk) disable iff (!rstN)
    penable && !pready |=> $stable(paddr) && $stable(pwrite))
    else begin
      assertFails++;
      $error("paddr or pwrite changed during access phase");
    end

  ////////////////////
  // run control
  noBusWhenHalted: assert property (@(posedge clk) disable iff (!rstN) halted |-> !psel)
    else begin
      assertFails++;
      $error("psel high while halted");
    end

  haltedUntilRun: assert property (@(posedge clk) disable iff (!rstN)
    halted && !run |=> halted)
    else begin
      assertFails++;
      $error("halted dropped without run");
    end

endmodule

bind coreTop coreTb_sva sva_i (
  .clk, .rstN, .run, .halted, .psel, .penable, .pready, .pwrite, .paddr
);

`default_nettype wire

// ==== source/coreTop.sv ====
////////////////////
// two-stage core, word-addressed imem loaded while idle
////////////////////
`timescale 1ns/1ps
`default_nettype none

module coreTop #(
  parameter int imemDepth = 64
) (
  input  logic           clk,
  input  logic           rstN,
  // program load
  input  logic           imemWe,
  input  corePkg::word_t imemAddr,
  input  corePkg::word_t imemWdata,
  input  logic           run,
  // status
  output logic           halted,
  output logic           busFault,
  // apb master
  output corePkg::word_t paddr,
  output logic           psel,
  output logic           penable,
  output logic           pwrite,
  output corePkg::word_t pwdata,
  input  corePkg::word_t prdata,
  input  logic           pready,
  input  logic           pslverr
);

  ////////////////////
  // stall and flush
  logic stallF, stallE, flushD, pcReset;

  // execute to controller
  logic memBusy, divStart, branchTaken, haltE, busErr;
  corePkg::instr_t instrD;
  corePkg::word_t  pcD, branchTarget;

  // divider hookup
  logic           divDone;
  corePkg::word_t dividend, divisor, quotient, remainder;

  memReqIf memIf();   // execute to apb

  hazardCtrl hzu (
    .clk, .rstN, .run,
    .memBusy, .divStart, .divDone, .branchTaken, .haltE, .busErr,
    .stallF, .stallE, .flushD, .pcReset, .halted, .busFault
  );  // global stall, flush and run control

  fetchUnit #(.imemDepth(imemDepth)) ifu (
    .clk, .rstN,
    .imemWe, .imemAddr, .imemWdata,
    .stallF, .flushD, .pcReset, .branchTaken, .branchTarget,
    .instrD, .pcD
  );  // imem, pc, decode register

  intExec ieu (
    .clk, .rstN, .instrD, .pcD, .stallE,
    .divDone, .quotient, .remainder,
    .branchTaken, .branchTarget, .memBusy, .divStart, .haltE,
    .dividend, .divisor,
    .memPort(memIf)
  );  // regfile, alu, branch, mem issue

  iterDivider div (
    .clk, .rstN, .divStart, .dividend, .divisor,
    .quotient, .remainder, .divDone
  );

  apbMaster ebu (
    .clk, .rstN,
    .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr,
    .busErr,
    .memBus(memIf)
  );  // external bus unit

endmodule

`default_nettype wire

// ==== source/apbMaster.sv ====
////////////////////
// single outstanding transfer, no pprot or pstrb
////////////////////
`timescale 1ns/1ps
`default_nettype none

module apbMaster (
  input  logic           clk,
  input  logic           rstN,
  output corePkg::word_t paddr,
  output logic           psel,
  output logic           penable,
  output logic           pwrite,
  output corePkg::word_t pwdata,
  input  corePkg::word_t prdata,
  input  logic           pready,
  input  logic           pslverr,
  output logic           busErr,
  memReqIf.bus           memBus
);

  typedef enum logic [1:0] {PH_IDLE, PH_SETUP, PH_ACCESS} phase_t;

  phase_t phase;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      phase <= PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE:   if (memBus.valid) phase <= PH_SETUP;   // setup the cycle after issue
        PH_SETUP:  phase <= PH_ACCESS;
        PH_ACCESS: if (pready) phase <= PH_IDLE;          // wait states hold here
        default:   phase <= PH_IDLE;
      endcase
    end
  end

  // request captured at issue, stable through access
  always_ff @(posedge clk) begin
    if (phase == PH_IDLE && memBus.valid) begin
      paddr  <= memBus.addr;
      pwdata <= memBus.wdata;
      pwrite <= memBus.write;
    end
  end

  assign psel    = (phase != PH_IDLE);
  assign penable = (phase == PH_ACCESS);

  ////////////////////
  // completion back to execute
  assign memBus.done  = penable && pready;
  assign memBus.rdata = prdata;                    // same cycle as done
  assign memBus.err   = memBus.done && pslverr;
  assign busErr       = memBus.err;                // to controller

endmodule

`default_nettype wire

// ==== execute/iterDivider.sv ====
////////////////////
// unsigned restoring divide, 1 load cycle + 32 steps
////////////////////
`timescale 1ns/1ps
`default_nettype none

module iterDivider (
  input  logic           clk,
  input  logic           rstN,
  input  logic           divStart,
  input  corePkg::word_t dividend,
  input  corePkg::word_t divisor,
  output corePkg::word_t quotient,
  output corePkg::word_t remainder,
  output logic           divDone
);

  localparam int w = corePkg::xlen;

  logic [5:0]     count;   // steps left, 0 = idle
  logic           load;
  corePkg::word_t divisorR, quo, rem;
  logic [w:0]     remShift, diff;

  // start ignored while stepping and in the done cycle
  assign load = (count == '0) && divStart && !divDone;

  // shift in next dividend bit, trial subtract
  assign remShift = {rem, quo[w-1]};
  assign diff     = remShift - {1'b0, divisorR};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      count   <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= (count == 6'd1);   // pulse after last step
      if (count != '0) begin
        count <= count - 1'b1;
      end else if (load) begin
        count <= 6'(w);
      end
    end
  end

  // divisor 0 never borrows, so quo all ones and rem = dividend
  always_ff @(posedge clk) begin
    if (load) begin
      quo      <= dividend;
      rem      <= '0;
      divisorR <= divisor;
    end else if (count != '0) begin
      if (!diff[w]) begin
        rem <= diff[w-1:0];   // fits, keep difference
        quo <= {quo[w-2:0], 1'b1};
      end else begin
        rem <= remShift[w-1:0];   // restore
        quo <= {quo[w-2:0], 1'b0};
      end
    end
  end

  assign quotient  = quo;
  assign remainder = rem;

endmodule

`default_nettype wire

// ==== execute/intExec.sv ====
////////////////////
// single execute stage, rd written at the end of the stage
////////////////////
`timescale 1ns/1ps
`default_nettype none

module intExec (
  input  logic            clk,
  input  logic            rstN,
  input  corePkg::instr_t instrD,
  input  corePkg::word_t  pcD,
  input  logic            stallE,
  input  logic            divDone,
  input  corePkg::word_t  quotient,
  input  corePkg::word_t  remainder,
  output logic            branchTaken,
  output corePkg::word_t  branchTarget,
  output logic            memBusy,
  output logic            divStart,
  output logic            haltE,
  output corePkg::word_t  dividend,
  output corePkg::word_t  divisor,
  memReqIf.exec           memPort
);

  corePkg::word_t regs [16];
  corePkg::word_t rs1Val, rs2Val, immExt, aluRes, wbData;
  logic isAlu, isLoad, isStore, isDiv, wbEn;

  ////////////////////
  // decode
  assign isAlu   = instrD.op inside {corePkg::OP_ADD, corePkg::OP_SUB, corePkg::OP_AND,
                                     corePkg::OP_XOR, corePkg::OP_ADDI};
  assign isLoad  = (instrD.op == corePkg::OP_LOAD);
  assign isStore = (instrD.op == corePkg::OP_STORE);
  assign isDiv   = instrD.op inside {corePkg::OP_DIVU, corePkg::OP_REMU};
  assign immExt  = {{16{instrD.imm[15]}}, instrD.imm};   // sign extend

  // r0 reads zero
  assign rs1Val = (instrD.rs1 == '0) ? '0 : regs[instrD.rs1];
  assign rs2Val = (instrD.rs2 == '0) ? '0 : regs[instrD.rs2];

  always_comb begin
    case (instrD.op)
      corePkg::OP_ADD:  aluRes = rs1Val + rs2Val;
      corePkg::OP_SUB:  aluRes = rs1Val - rs2Val;
      corePkg::OP_AND:  aluRes = rs1Val & rs2Val;
      corePkg::OP_XOR:  aluRes = rs1Val ^ rs2Val;
      corePkg::OP_ADDI: aluRes = rs1Val + immExt;
      default:          aluRes = '0;
    endcase
  end

  // branch, target in words from the branch pc
  assign branchTaken  = (instrD.op == corePkg::OP_BEQ) && (rs1Val == rs2Val) && !stallE;
  assign branchTarget = pcD + immExt;
  assign haltE        = (instrD.op == corePkg::OP_HALT) && !stallE;

  ////////////////////
  // memory request, held by the stall until done
  assign memPort.valid = isLoad || isStore;
  assign memPort.write = isStore;
  assign memPort.addr  = rs1Val + immExt;
  assign memPort.wdata = rs2Val;
  assign memBusy       = memPort.valid && !memPort.done;

  // divider operands stay put while stalled
  assign divStart = isDiv;
  assign dividend = rs1Val;
  assign divisor  = rs2Val;

  ////////////////////
  // writeback select
  always_comb begin
    wbEn   = 1'b0;
    wbData = aluRes;
    if (isAlu) begin
      wbEn = !stallE;
    end else if (isLoad) begin
      wbEn   = memPort.done && !memPort.err;   // faulting load writes nothing
      wbData = memPort.rdata;
    end else if (isDiv) begin
      wbEn   = divDone;
      wbData = (instrD.op == corePkg::OP_DIVU) ? quotient : remainder;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn && instrD.rd != '0) begin
      regs[instrD.rd] <= wbData;   // r0 never written
    end
  end

endmodule

`default_nettype wire

// ==== source/fetchUnit.sv ====
////////////////////
// imemDepth a power of two, pc counts words and wraps
////////////////////
`timescale 1ns/1ps
`default_nettype none

module fetchUnit #(
  parameter int imemDepth = 64
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            imemWe,
  input  corePkg::word_t  imemAddr,
  input  corePkg::word_t  imemWdata,
  input  logic            stallF,
  input  logic            flushD,
  input  logic            pcReset,
  input  logic            branchTaken,
  input  corePkg::word_t  branchTarget,
  output corePkg::instr_t instrD,
  output corePkg::word_t  pcD
);

  localparam int addrW = (imemDepth > 1) ? $clog2(imemDepth) : 1;
  // unused opcode 15 decodes as nop
  localparam corePkg::instr_t nopInstr = corePkg::instr_t'(32'hF000_0000);

  corePkg::word_t imem [imemDepth];
  corePkg::word_t pcF;
  corePkg::word_t instrF;

  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr[addrW-1:0]] <= imemWdata;   // load port, core idle
    end
  end

  assign instrF = imem[pcF[addrW-1:0]];   // async read

  always_ff @(posedge clk) begin
    if (!rstN || pcReset) begin
      pcF <= '0;
    end else if (branchTaken) begin
      pcF <= branchTarget;   // redirect beats stall
    end else if (!stallF) begin
      pcF <= pcF + 1'b1;
    end
  end

  // decode register, flush drops the fetched word
  always_ff @(posedge clk) begin
    if (!rstN || flushD) begin
      instrD <= nopInstr;
    end else if (!stallF) begin
      instrD <= corePkg::instr_t'(instrF);
    end
  end

  always_ff @(posedge clk) begin
    if (!stallF) begin
      pcD <= pcF;   // tag for branch target
    end
  end

endmodule

`default_nettype wire

// ==== source/hazardCtrl.sv ====
////////////////////
// core frozen in idle and halted, run restarts from pc 0
////////////////////
`timescale 1ns/1ps
`default_nettype none

module hazardCtrl (
  input  logic clk,
  input  logic rstN,
  input  logic run,
  input  logic memBusy,
  input  logic divStart,
  input  logic divDone,
  input  logic branchTaken,
  input  logic haltE,
  input  logic busErr,
  output logic stallF,
  output logic stallE,
  output logic flushD,
  output logic pcReset,
  output logic halted,
  output logic busFault
);

  corePkg::ctrlState_t state, stateNext;
  logic frozen, start, inRun, memStall, divStall;

  assign frozen = (state == corePkg::S_IDLE) || (state == corePkg::S_HALTED);
  assign start  = frozen && run;   // run ignored elsewhere
  assign inRun  = (state == corePkg::S_RUN);

  // hold from issue until done
  assign memStall = (inRun || state == corePkg::S_MEMWAIT) && memBusy;
  // divider needs 33 cycles, release in the done cycle
  assign divStall = (inRun && divStart) || (state == corePkg::S_DIVWAIT && !divDone);

  assign stallE  = frozen || memStall || divStall;
  assign stallF  = stallE || (inRun && haltE);   // stop fetching behind halt
  assign flushD  = start || busErr || (inRun && (branchTaken || haltE));
  assign pcReset = start;
  assign halted  = (state == corePkg::S_HALTED);

  ////////////////////
  // next state
  always_comb begin
    stateNext = state;
    case (state)
      corePkg::S_IDLE, corePkg::S_HALTED: begin
        if (run) stateNext = corePkg::S_RUN;
      end
      corePkg::S_RUN: begin
        if (haltE)         stateNext = corePkg::S_HALTED;
        else if (memBusy)  stateNext = corePkg::S_MEMWAIT;
        else if (divStart) stateNext = corePkg::S_DIVWAIT;
      end
      corePkg::S_MEMWAIT: begin
        if (busErr)        stateNext = corePkg::S_HALTED;  // fault stops the core
        else if (!memBusy) stateNext = corePkg::S_RUN;
      end
      corePkg::S_DIVWAIT: begin
        if (divDone) stateNext = corePkg::S_RUN;
      end
      default: stateNext = corePkg::S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state    <= corePkg::S_IDLE;
      busFault <= 1'b0;
    end else begin
      state <= stateNext;
      if (busErr) begin
        busFault <= 1'b1;   // sticky
      end else if (start) begin
        busFault <= 1'b0;   // cleared by next run
      end
    end
  end

endmodule

`default_nettype wire

// ==== common/memReqIf.sv ====
////////////////////
// one request in flight, valid held until the done pulse
////////////////////
`timescale 1ns/1ps
`default_nettype none

interface memReqIf;

  logic           valid;   // load or store sitting in execute
  logic           write;   // 1 = store
  corePkg::word_t addr;
  corePkg::word_t wdata;
  corePkg::word_t rdata;   // good only with done
  logic           done;    // one-cycle pulse
  logic           err;     // slave error, qualifies done

  // execute side issues
  modport exec (output valid, write, addr, wdata, input rdata, done, err);
  // bus unit side answers
  modport bus (input valid, write, addr, wdata, output rdata, done, err);

endinterface

`default_nettype wire

// ==== common/corePkg.sv ====
////////////////////
// fixed 32-bit encoding, 16 registers, r0 hardwired to zero
// opcodes 11..15 are not decoded and execute as no-ops
////////////////////
`default_nettype none

package corePkg;

  parameter int xlen = 32;           // data path width

  typedef logic [xlen-1:0] word_t;   // regs, bus data, addresses
  typedef logic [3:0]      regIdx_t;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_AND   = 4'd2,
    OP_XOR   = 4'd3,
    OP_ADDI  = 4'd4,
    OP_LOAD  = 4'd5,   // rd = mem[rs1 + imm]
    OP_STORE = 4'd6,   // mem[rs1 + imm] = rs2
    OP_BEQ   = 4'd7,   // pc-relative, in words
    OP_DIVU  = 4'd8,
    OP_REMU  = 4'd9,
    OP_HALT  = 4'd10
  } opcode_t;

  // msb first, matches the instruction word
  typedef struct packed {
    opcode_t     op;    // 31..28
    regIdx_t     rd;    // 27..24
    regIdx_t     rs1;   // 23..20
    regIdx_t     rs2;   // 19..16
    logic [15:0] imm;   // signed
  } instr_t;

  typedef enum logic [2:0] {
    S_IDLE, S_RUN, S_MEMWAIT, S_DIVWAIT, S_HALTED
  } ctrlState_t;

endpackage

`default_nettype wire
